/* axi_lite_clint_slave.sv */
`include "clint_settings.svh"

module axi_lite_clint_slave
    import clint_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,

    // read address / data
    input  logic [`CLINT_ADDR_W-1:0]  araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [`CLINT_DATA_W-1:0]  rdata,
    output logic [`CLINT_RESP_W-1:0]  rresp,
    output logic                      rvalid,
    input  logic                      rready,

    // write address / data / response
    input  logic [`CLINT_ADDR_W-1:0]  awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [`CLINT_DATA_W-1:0]  wdata,
    input  logic [`CLINT_STRB_W-1:0]  wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [`CLINT_RESP_W-1:0]  bresp,
    output logic                      bvalid,
    input  logic                      bready,

    // register block link
    output clint_req_t                req,
    input  clint_rsp_t                rsp
);

    slv_state_e state_q;
    slv_state_e state_d;

    logic                          ar_hs;
    logic                          aw_hs;
    logic                          w_hs;
    logic                          req_valid_q;
    logic                          req_write_q;
    logic [`CLINT_REG_ADDR_W-1:0]  req_addr_q;
    logic [`CLINT_DATA_W-1:0]      req_wdata_q;
    logic [`CLINT_STRB_W-1:0]      req_wstrb_q;
    logic                          rvalid_q;
    logic                          bvalid_q;
    logic [`CLINT_DATA_W-1:0]      rdata_q;
    logic [`CLINT_RESP_W-1:0]      resp_q;

    assign arready = (state_q == st_idle);
    assign awready = (state_q == st_idle);
    assign wready  = (state_q == st_wait_w);

    // ar has priority over aw in idle
    assign ar_hs = arvalid && arready;
    assign aw_hs = awvalid && awready && !arvalid;
    assign w_hs  = wvalid && wready;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            st_idle: begin
                if (ar_hs) begin
                    state_d = st_read;
                end else if (aw_hs) begin
                    state_d = st_wait_w;
                end
            end
            st_read: begin
                if (rvalid_q && rready) begin
                    state_d = st_idle;
                end
            end
            st_wait_w: begin
                if (w_hs) begin
                    state_d = st_write;
                end
            end
            st_write: begin
                if (bvalid_q && bready) begin
                    state_d = st_idle;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= st_idle;
            req_valid_q <= 1'b0;
            rvalid_q    <= 1'b0;
            bvalid_q    <= 1'b0;
        end else begin
            state_q     <= state_d;
            // one pulse per transaction
            req_valid_q <= ar_hs || w_hs;
            if (rsp.valid && state_q == st_read) begin
                rvalid_q <= 1'b1;
            end else if (rvalid_q && rready) begin
                rvalid_q <= 1'b0;
            end
            if (rsp.valid && state_q == st_write) begin
                bvalid_q <= 1'b1;
            end else if (bvalid_q && bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            req_addr_q  <= araddr[`CLINT_REG_ADDR_W-1:0];
            req_write_q <= 1'b0;
        end else if (aw_hs) begin
            req_addr_q  <= awaddr[`CLINT_REG_ADDR_W-1:0];
            req_write_q <= 1'b1;
        end
        if (w_hs) begin
            req_wdata_q <= wdata;
            req_wstrb_q <= wstrb;
        end
        if (rsp.valid) begin
            rdata_q <= rsp.rdata;
            resp_q  <= rsp.err ? `CLINT_RESP_SLVERR : `CLINT_RESP_OKAY;
        end
    end

    assign req = '{valid: req_valid_q, write: req_write_q, addr: req_addr_q,
                   wdata: req_wdata_q, wstrb: req_wstrb_q};

    assign rvalid = rvalid_q;
    assign rdata  = rdata_q;
    assign rresp  = resp_q;
    assign bvalid = bvalid_q;
    assign bresp  = resp_q;

endmodule

/* clint_irq.sv */
module clint_irq (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [63:0]  mtime,
    input  logic [63:0]  mtimecmp,
    input  logic         msip_bit,
    output logic         mtip,
    output logic         msip_irq
);

    logic mtip_q;
    logic msip_irq_q;

    // wide compare ends at a flop
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtip_q <= 1'b0;
        end else begin
            mtip_q <= (mtime >= mtimecmp);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            msip_irq_q <= 1'b0;
        end else begin
            msip_irq_q <= msip_bit;
        end
    end

    assign mtip     = mtip_q;
    assign msip_irq = msip_irq_q;

endmodule

/* clint_pkg.sv */
`include "clint_settings.svh"

package clint_pkg;

    // one register access from the bus slave
    typedef struct packed {
        logic                          valid;
        logic                          write;
        logic [`CLINT_REG_ADDR_W-1:0]  addr;
        logic [`CLINT_DATA_W-1:0]      wdata;
        logic [`CLINT_STRB_W-1:0]      wstrb;
    } clint_req_t;

    // result one cycle after the request
    typedef struct packed {
        logic                      valid;
        logic                      err;
        logic [`CLINT_DATA_W-1:0]  rdata;
    } clint_rsp_t;

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_wait_w,
        st_write
    } slv_state_e;

    typedef enum logic [2:0] {
        sel_mtime_lo,
        sel_mtime_hi,
        sel_mtimecmp_lo,
        sel_mtimecmp_hi,
        sel_msip,
        sel_ctrl,
        sel_none
    } clint_reg_e;

endpackage

/* clint_regs.sv */
`include "clint_settings.svh"

module clint_regs
    import clint_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  clint_req_t   req,
    output clint_rsp_t   rsp,
    output logic [63:0]  mtime,
    output logic [63:0]  mtimecmp,
    output logic         msip_bit
);

    clint_reg_e sel;

    logic                      wr_en;
    logic [63:0]               mtime_q;
    logic [63:0]               mtimecmp_q;
    logic                      msip_q;
    logic                      ctrl_q;
    logic [`CLINT_DATA_W-1:0]  rd_data;
    logic                      rsp_valid_q;
    logic                      rsp_err_q;
    logic [`CLINT_DATA_W-1:0]  rsp_rdata_q;

    function automatic logic [`CLINT_DATA_W-1:0] byte_merge(
        input logic [`CLINT_DATA_W-1:0] old_val,
        input logic [`CLINT_DATA_W-1:0] new_val,
        input logic [`CLINT_STRB_W-1:0] strb
    );
        logic [`CLINT_DATA_W-1:0] res;
        res = old_val;
        for (int i = 0; i < `CLINT_STRB_W; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

    always_comb begin
        case (req.addr)
            `CLINT_OFF_MTIME_LO:    sel = sel_mtime_lo;
            `CLINT_OFF_MTIME_HI:    sel = sel_mtime_hi;
            `CLINT_OFF_MTIMECMP_LO: sel = sel_mtimecmp_lo;
            `CLINT_OFF_MTIMECMP_HI: sel = sel_mtimecmp_hi;
            `CLINT_OFF_MSIP:        sel = sel_msip;
            `CLINT_OFF_CTRL:        sel = sel_ctrl;
            default:                sel = sel_none;
        endcase
    end

    assign wr_en = req.valid && req.write;

    // bus write wins over the increment
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime_q <= `CLINT_MTIME_RST;
        end else if (wr_en && sel == sel_mtime_lo) begin
            mtime_q[31:0] <= byte_merge(mtime_q[31:0], req.wdata, req.wstrb);
        end else if (wr_en && sel == sel_mtime_hi) begin
            mtime_q[63:32] <= byte_merge(mtime_q[63:32], req.wdata, req.wstrb);
        end else if (ctrl_q) begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtimecmp_q <= `CLINT_MTIMECMP_RST;
            msip_q     <= `CLINT_MSIP_RST;
            ctrl_q     <= `CLINT_CTRL_RST;
        end else if (wr_en) begin
            case (sel)
                sel_mtimecmp_lo: begin
                    mtimecmp_q[31:0] <= byte_merge(mtimecmp_q[31:0], req.wdata, req.wstrb);
                end
                sel_mtimecmp_hi: begin
                    mtimecmp_q[63:32] <= byte_merge(mtimecmp_q[63:32], req.wdata, req.wstrb);
                end
                sel_msip: begin
                    if (req.wstrb[0]) begin
                        msip_q <= req.wdata[0];
                    end
                end
                sel_ctrl: begin
                    if (req.wstrb[0]) begin
                        ctrl_q <= req.wdata[0];
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // values before this cycle's update
    always_comb begin
        case (sel)
            sel_mtime_lo:    rd_data = mtime_q[31:0];
            sel_mtime_hi:    rd_data = mtime_q[63:32];
            sel_mtimecmp_lo: rd_data = mtimecmp_q[31:0];
            sel_mtimecmp_hi: rd_data = mtimecmp_q[63:32];
            sel_msip:        rd_data = {31'b0, msip_q};
            sel_ctrl:        rd_data = {31'b0, ctrl_q};
            default:         rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= req.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid) begin
            rsp_rdata_q <= rd_data;
            rsp_err_q   <= (sel == sel_none);
        end
    end

    assign rsp      = '{valid: rsp_valid_q, err: rsp_err_q, rdata: rsp_rdata_q};
    assign mtime    = mtime_q;
    assign mtimecmp = mtimecmp_q;
    assign msip_bit = msip_q;

endmodule

/* clint_settings.svh */
`ifndef CLINT_SETTINGS_SVH
`define CLINT_SETTINGS_SVH

// axi-lite bus widths
`define CLINT_ADDR_W 32
`define CLINT_DATA_W 32
`define CLINT_STRB_W 4
`define CLINT_RESP_W 2

// offsets within the low 5 address bits
`define CLINT_REG_ADDR_W      5
`define CLINT_OFF_MTIME_LO    5'h00
`define CLINT_OFF_MTIME_HI    5'h04
`define CLINT_OFF_MTIMECMP_LO 5'h08
`define CLINT_OFF_MTIMECMP_HI 5'h0c
`define CLINT_OFF_MSIP        5'h10
`define CLINT_OFF_CTRL        5'h14

// reset values
`define CLINT_MTIME_RST    64'h0000_0000_0000_0000
`define CLINT_MTIMECMP_RST 64'hffff_ffff_ffff_ffff
`define CLINT_MSIP_RST     1'b0
`define CLINT_CTRL_RST     1'b1

// response codes
`define CLINT_RESP_OKAY   2'b00
`define CLINT_RESP_SLVERR 2'b10

`endif

/* clint_tb.sv */
`include "clint_settings.svh"

module clint_tb;

    typedef struct packed {
        logic [1:0]  op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [1:0]  mode;
        logic [1:0]  mtip;
    } entry_t;

    localparam logic [1:0] OP_RD = 2'd0;
    localparam logic [1:0] OP_WR = 2'd1;
    localparam logic [1:0] OP_IDLE = 2'd2;

    logic clk, rst_n;
    logic [31:0] araddr, awaddr, wdata, rdata;
    logic [3:0] wstrb;
    logic [1:0] rresp, bresp;
    logic arvalid, arready, rvalid, rready, awvalid, awready;
    logic wvalid, wready, bvalid, bready, mtip, msip_irq;

    entry_t tbl[64];
    int n_ent = 0;
    int idle_sum = 0;
    bit tbl_ready = 0;
    int cyc = 0;
    int n_err = 0;
    int cur = 0;
    logic [31:0] rng = 32'd55768;

    // reference copy of the register map
    logic [63:0] m_mtime = 64'h0;
    logic [63:0] m_cmp = `CLINT_MTIMECMP_RST;
    logic m_msip = 1'b0;
    logic m_ctrl = 1'b1;

    tb_clk_gen clk_gen0 (.clk(clk), .rst_n(rst_n));

    clint_top dut0 (
        .clk(clk), .rst_n(rst_n),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .mtip(mtip), .msip_irq(msip_irq)
    );

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] rand_word();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_v,
                                                input logic [31:0] new_v,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old_v;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) res[8*i +: 8] = new_v[8*i +: 8];
        end
        return res;
    endfunction

    function automatic bit mapped(input logic [31:0] a);
        case (a[4:0])
            5'h00, 5'h04, 5'h08, 5'h0c, 5'h10, 5'h14: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] model_read(input logic [31:0] a);
        case (a[4:0])
            5'h00: return m_mtime[31:0];
            5'h04: return m_mtime[63:32];
            5'h08: return m_cmp[31:0];
            5'h0c: return m_cmp[63:32];
            5'h10: return {31'b0, m_msip};
            5'h14: return {31'b0, m_ctrl};
            default: return 32'h0;
        endcase
    endfunction

    task automatic model_write(input logic [31:0] a, input logic [31:0] d,
                               input logic [3:0] s);
        case (a[4:0])
            5'h00: m_mtime[31:0] = merge_bytes(m_mtime[31:0], d, s);
            5'h04: m_mtime[63:32] = merge_bytes(m_mtime[63:32], d, s);
            5'h08: m_cmp[31:0] = merge_bytes(m_cmp[31:0], d, s);
            5'h0c: m_cmp[63:32] = merge_bytes(m_cmp[63:32], d, s);
            5'h10: if (s[0]) m_msip = d[0];
            5'h14: if (s[0]) m_ctrl = d[0];
            default: ;
        endcase
    endtask

    // mode 1 checks rdata against the model
    // mode 2 checks the mtime step
    // mtip field 2 takes the model compare and 3 skips it
    task automatic add(input logic [1:0] op, input logic [31:0] a, input logic [31:0] d,
                       input logic [3:0] s, input logic [1:0] mode, input logic [1:0] mt);
        tbl[n_ent] = '{op: op, addr: a, data: d, strb: s, mode: mode, mtip: mt};
        if (op == OP_IDLE) idle_sum += int'(d);
        n_ent++;
    endtask

    task automatic hs_error(input string what);
        $display("entry %0d: %s", cur, what);
        n_err++;
    endtask

    task automatic wait_high(ref logic sig, input string what, output bit ok);
        int k;
        k = 0;
        @(negedge clk);
        while (!sig && k < 40) begin
            @(negedge clk);
            k++;
        end
        ok = sig;
        if (!ok) hs_error(what);
    endtask

    task automatic do_read(input logic [31:0] a, output logic [31:0] d, output logic [1:0] r,
                           output int hs_cyc, output int lat, output bit ok);
        int k;
        int dly;
        logic [31:0] first;
        ok = 1'b1;
        d = '0;
        r = '0;
        lat = 0;
        @(posedge clk);
        araddr <= a;
        arvalid <= 1'b1;
        wait_high(arready, "read address was never accepted", ok);
        hs_cyc = cyc;
        @(posedge clk);
        arvalid <= 1'b0;
        if (!ok) return;
        @(negedge clk);
        k = 0;
        while (!rvalid && k < 40) begin
            @(negedge clk);
            k++;
        end
        lat = k;
        if (!rvalid) begin
            hs_error("read data never arrived");
            ok = 1'b0;
            return;
        end
        first = rdata;
        dly = int'(rand_word() & 32'h3);
        repeat (dly) begin
            @(negedge clk);
            if (!rvalid || rdata != first) begin
                hs_error("read response changed before rready");
                ok = 1'b0;
            end
        end
        @(posedge clk);
        rready <= 1'b1;
        @(negedge clk);
        d = rdata;
        r = rresp;
        if (!rvalid) begin
            hs_error("rvalid dropped before rready");
            ok = 1'b0;
        end
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic do_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s,
                            output logic [1:0] r, output bit ok);
        int dly;
        r = '0;
        @(posedge clk);
        awaddr <= a;
        awvalid <= 1'b1;
        wdata <= d;
        wstrb <= s;
        wvalid <= 1'b1;
        wait_high(awready, "write address was never accepted", ok);
        @(posedge clk);
        awvalid <= 1'b0;
        if (!ok) return;
        wait_high(wready, "write data was never accepted", ok);
        @(posedge clk);
        wvalid <= 1'b0;
        if (!ok) return;
        wait_high(bvalid, "write response never arrived", ok);
        if (!ok) return;
        dly = int'(rand_word() & 32'h3);
        repeat (dly) begin
            @(negedge clk);
            if (!bvalid) begin
                hs_error("write response dropped before bready");
                ok = 1'b0;
            end
        end
        @(posedge clk);
        bready <= 1'b1;
        @(negedge clk);
        r = bresp;
        if (!bvalid) begin
            hs_error("bvalid dropped before bready");
            ok = 1'b0;
        end
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic build_table();
        // reset values
        add(OP_RD, 32'h08, 0, 0, 1, 0);
        add(OP_RD, 32'h0c, 0, 0, 1, 0);
        add(OP_RD, 32'h10, 0, 0, 1, 0);
        add(OP_RD, 32'h14, 0, 0, 1, 0);
        // stop the counter, then byte merges
        add(OP_WR, 32'h14, 32'h0, 4'hf, 0, 0);
        add(OP_WR, 32'h00, rand_word(), 4'hf, 0, 0);
        add(OP_WR, 32'h04, 32'h1, 4'hf, 0, 2);
        add(OP_RD, 32'h00, 0, 0, 1, 2);
        add(OP_RD, 32'h04, 0, 0, 1, 2);
        add(OP_WR, 32'h00, 32'ha5a5_a5a5, 4'h5, 0, 2);
        add(OP_RD, 32'h00, 0, 0, 1, 2);
        add(OP_WR, 32'h04, rand_word(), 4'ha, 0, 2);
        add(OP_RD, 32'h04, 0, 0, 1, 2);
        add(OP_WR, 32'h0c, 32'h0, 4'hf, 0, 2);
        add(OP_WR, 32'h08, rand_word(), 4'h6, 0, 2);
        add(OP_RD, 32'h08, 0, 0, 1, 2);
        add(OP_RD, 32'h0c, 0, 0, 1, 2);
        // compare with the counter stopped
        add(OP_WR, 32'h04, 32'h0, 4'hf, 0, 2);
        add(OP_WR, 32'h00, 32'h100, 4'hf, 0, 2);
        add(OP_WR, 32'h08, 32'h100, 4'hf, 0, 2);
        add(OP_WR, 32'h08, 32'h101, 4'hf, 0, 2);
        add(OP_WR, 32'h00, 32'h200, 4'hf, 0, 2);
        add(OP_WR, 32'h08, 32'h80, 4'hf, 0, 2);
        add(OP_WR, 32'h00, 32'h0, 4'hf, 0, 2);
        // counting reaches mtimecmp
        add(OP_WR, 32'h14, 32'h1, 4'hf, 0, 0);
        add(OP_IDLE, 0, 150, 0, 0, 1);
        add(OP_WR, 32'h08, 32'hffff_ffff, 4'hf, 0, 0);
        add(OP_WR, 32'h0c, 32'hffff_ffff, 4'hf, 0, 0);
        add(OP_RD, 32'h00, 0, 0, 2, 0);
        add(OP_RD, 32'h00, 0, 0, 2, 0);
        add(OP_IDLE, 0, 7, 0, 0, 0);
        add(OP_RD, 32'h00, 0, 0, 2, 0);
        // software interrupt
        add(OP_WR, 32'h10, 32'h1, 4'hf, 0, 0);
        add(OP_WR, 32'h10, 32'h0, 4'h0, 0, 0);
        add(OP_RD, 32'h10, 0, 0, 1, 0);
        add(OP_WR, 32'h10, 32'h0, 4'hf, 0, 0);
        // decode errors
        add(OP_WR, 32'h14, 32'h0, 4'hf, 0, 3);
        add(OP_WR, 32'h00, 32'h1234_5678, 4'hf, 0, 3);
        add(OP_WR, 32'h04, 32'h0, 4'hf, 0, 2);
        add(OP_RD, 32'h18, 0, 0, 1, 2);
        add(OP_WR, 32'h1c, rand_word(), 4'hf, 0, 2);
        add(OP_WR, 32'h18, 32'hffff_ffff, 4'hf, 0, 2);
        add(OP_RD, 32'h00, 0, 0, 1, 2);
        add(OP_RD, 32'h04, 0, 0, 1, 2);
        add(OP_RD, 32'h08, 0, 0, 1, 2);
        add(OP_RD, 32'h0c, 0, 0, 1, 2);
        add(OP_RD, 32'h10, 0, 0, 1, 2);
        add(OP_RD, 32'h14, 0, 0, 1, 2);
        add(OP_RD, 32'h0200_0008, 0, 0, 1, 2);
        add(OP_RD, 32'h1c, 0, 0, 1, 2);
    endtask

    initial begin
        wait (tbl_ready);
        repeat (n_ent * 20 + idle_sum + 10) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", cyc);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        entry_t e;
        logic [31:0] got;
        logic [31:0] exp_d;
        logic [31:0] prev_d;
        logic [1:0] got_r;
        logic [1:0] exp_r;
        logic exp_mtip;
        int hs_cyc;
        int prev_cyc;
        int lat;
        int errs0;
        int n_pass;
        int n_fail;
        bit ok;
        bit have_prev;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        n_pass = 0;
        n_fail = 0;
        have_prev = 1'b0;
        prev_d = '0;
        prev_cyc = 0;
        build_table();
        tbl_ready = 1'b1;
        wait (rst_n);
        for (int i = 0; i < n_ent; i++) begin
            e = tbl[i];
            cur = i;
            errs0 = n_err;
            exp_r = mapped(e.addr) ? `CLINT_RESP_OKAY : `CLINT_RESP_SLVERR;
            if (e.op == OP_RD) begin
                exp_d = model_read(e.addr);
                do_read(e.addr, got, got_r, hs_cyc, lat, ok);
                if (ok && got_r != exp_r) begin
                    $display("Fail entry %0d rresp: expected %0h, got %0h", i, exp_r, got_r);
                    n_err++;
                end
                if (ok && lat != 2) begin
                    $display("Fail entry %0d rvalid latency: expected %0h, got %0h",
                             i, 2, lat);
                    n_err++;
                end
                if (ok && e.mode == 2'd1 && got != exp_d) begin
                    $display("Fail entry %0d rdata: expected %08h, got %08h", i, exp_d, got);
                    n_err++;
                end
                if (ok && e.mode == 2'd2) begin
                    // step may exceed the edge count by one
                    if (have_prev && (got - prev_d < 32'(hs_cyc - prev_cyc) ||
                                      got - prev_d > 32'(hs_cyc - prev_cyc + 1))) begin
                        $display("Fail entry %0d mtime_lo step: expected %0h, got %0h",
                                 i, hs_cyc - prev_cyc, got - prev_d);
                        n_err++;
                    end
                    have_prev = 1'b1;
                    prev_d = got;
                    prev_cyc = hs_cyc;
                end
            end else if (e.op == OP_WR) begin
                do_write(e.addr, e.data, e.strb, got_r, ok);
                if (ok && got_r != exp_r) begin
                    $display("Fail entry %0d bresp: expected %0h, got %0h", i, exp_r, got_r);
                    n_err++;
                end
                model_write(e.addr, e.data, e.strb);
            end else begin
                repeat (e.data) @(posedge clk);
            end
            repeat (2) @(posedge clk);
            @(negedge clk);
            exp_mtip = (e.mtip == 2'd2) ? (m_mtime >= m_cmp) : e.mtip[0];
            if (e.mtip != 2'd3 && mtip != exp_mtip) begin
                $display("Fail entry %0d mtip: expected %0h, got %0h", i, exp_mtip, mtip);
                n_err++;
            end
            if (msip_irq != m_msip) begin
                $display("Fail entry %0d msip_irq: expected %0h, got %0h", i, m_msip, msip_irq);
                n_err++;
            end
            if (n_err == errs0) begin
                $display("entry %0d op %0d addr %08h ok", i, e.op, e.addr);
                n_pass++;
            end else begin
                $display("entry %0d op %0d addr %08h had errors", i, e.op, e.addr);
                n_fail++;
            end
        end
        $display("entries passed %0d, failed %0d", n_pass, n_fail);
        if (n_err == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* clint_top.sv */
`include "clint_settings.svh"

module clint_top
    import clint_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`CLINT_ADDR_W-1:0]  araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [`CLINT_DATA_W-1:0]  rdata,
    output logic [`CLINT_RESP_W-1:0]  rresp,
    output logic                      rvalid,
    input  logic                      rready,
    input  logic [`CLINT_ADDR_W-1:0]  awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [`CLINT_DATA_W-1:0]  wdata,
    input  logic [`CLINT_STRB_W-1:0]  wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [`CLINT_RESP_W-1:0]  bresp,
    output logic                      bvalid,
    input  logic                      bready,
    output logic                      mtip,
    output logic                      msip_irq
);

    clint_req_t   req;
    clint_rsp_t   rsp;
    logic [63:0]  mtime;
    logic [63:0]  mtimecmp;
    logic         msip_bit;

    axi_lite_clint_slave slv0 (
        .clk(clk), .rst_n(rst_n),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .req(req), .rsp(rsp)
    );

    clint_regs regs0 (
        .clk(clk), .rst_n(rst_n), .req(req), .rsp(rsp),
        .mtime(mtime), .mtimecmp(mtimecmp), .msip_bit(msip_bit)
    );

    clint_irq irq0 (
        .clk(clk), .rst_n(rst_n), .mtime(mtime), .mtimecmp(mtimecmp),
        .msip_bit(msip_bit), .mtip(mtip), .msip_irq(msip_irq)
    );

endmodule

/* flist.f */
+incdir+.
clint_pkg.sv
axi_lite_clint_slave.sv
clint_regs.sv
clint_irq.sv
clint_top.sv
tb_clk_gen.sv
clint_tb.sv

/* run.sh */
#!/bin/sh
# build and run the CLINT testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module clint_tb -o clint_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/clint_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF "*** TEST PASSED ***"; then
    exit 0
fi
echo "pass line not found"
exit 1

/* tb_clk_gen.sv */
module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held for 10 cycles
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule
